//--- design/vector_pkg.sv
//--------------------------------------
// Widths, I/O port map and constants of the
// memory and port subsystem. The Covox lock
// is far shorter than on the real machine.
//--------------------------------------
package vector_pkg;

	//--------------------------------------
	// Data widths
	//--------------------------------------

	// CPU side address
	typedef logic [15:0] cpu_addr_t;

	// Page number in 18:16, offset in 15:0
	typedef logic [18:0] ram_addr_t;

	typedef logic [7:0] byte_t;

	// 0 is the main bank, 1 to 4 the e-disk pages
	typedef logic [2:0] ed_page_t;

	// One bit per direction or button
	typedef logic [7:0] joy_t;

	// Main bank plus four e-disk pages
	localparam int RAM_DEPTH = 5 * 65536;

	//--------------------------------------
	// I/O port map
	//--------------------------------------
	localparam byte_t PORT_EDISK    = 8'h10;
	// 0x04 sets one mode bit, 0x05 loads the register
	localparam byte_t PORT_JOY_CTRL = 8'h04;
	localparam byte_t PORT_JOY_SEL  = 8'h06;
	localparam byte_t PORT_VOX      = 8'h07;
	localparam byte_t PORT_JOY_A    = 8'h0E;
	localparam byte_t PORT_JOY_B    = 8'h0F;

	//--------------------------------------
	// Misc constants
	//--------------------------------------

	// Covox writes are dropped this long after reset
	localparam int COVOX_LOCK_CYCLES = 1024;
	localparam int COVOX_TIMER_W     = $clog2(COVOX_LOCK_CYCLES + 1);

	// Floating bus value for unmapped ports
	localparam byte_t IO_IDLE_DATA = 8'hFF;

endpackage

//--- design/mem_bus_if.sv
//--------------------------------------
// One requester's RAM port. Valid holds with a
// stable request until ready; read data comes
// back with rvalid one cycle after the grant.
//--------------------------------------
`timescale 1ns/1ps

interface mem_bus_if import vector_pkg::*; ();

	logic      valid;
	logic      ready;
	logic      we;
	ram_addr_t addr;
	byte_t     wdata;
	byte_t     rdata;
	logic      rvalid;

	// Side that issues cycles
	modport requester (
		output valid, we, addr, wdata,
		input  ready, rdata, rvalid
	);

	// Side that owns the RAM
	modport arbiter (
		input  valid, we, addr, wdata,
		output ready, rdata, rvalid
	);

endinterface

//--- design/shared_ram.sv
//--------------------------------------
// Single port byte RAM, read registered.
// A read on a write cycle returns old data.
// Contents are not cleared by reset.
//--------------------------------------
`timescale 1ns/1ps

module shared_ram import vector_pkg::*; (
	input  logic      clk_sys,
	input  logic      we_i,
	input  ram_addr_t addr_i,
	input  byte_t     wdata_i,
	output byte_t     rdata_o
);

	// Main bank followed by e-disk pages 1 to 4
	byte_t mem [RAM_DEPTH];
	byte_t rdata_q;

	always_ff @(posedge clk_sys) begin
		if (we_i) begin
			mem[addr_i] <= wdata_i;
		end
		rdata_q <= mem[addr_i];
	end

	assign rdata_o = rdata_q;

endmodule

//--- design/mem_arbiter.sv
//--------------------------------------
// Fixed priority RAM arbiter, loader first.
// Ready is combinational from the loader's
// valid. Read latency is one cycle.
//--------------------------------------
`timescale 1ns/1ps

module mem_arbiter import vector_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	mem_bus_if.arbiter ld,
	mem_bus_if.arbiter cpu,
	output logic      ram_we_o,
	output ram_addr_t ram_addr_o,
	output byte_t     ram_wdata_o,
	input  byte_t     ram_rdata_i
);

	logic cpu_grant;
	logic ld_rd_q;
	logic cpu_rd_q;

	//--------------------------------------
	// Grant
	//--------------------------------------

	// Loader always wins, CPU waits while it is busy
	assign ld.ready  = ld.valid;
	assign cpu.ready = ~ld.valid;
	assign cpu_grant = cpu.valid & ~ld.valid;

	always_comb begin
		if (ld.valid) begin
			ram_we_o    = ld.we;
			ram_addr_o  = ld.addr;
			ram_wdata_o = ld.wdata;
		end else begin
			ram_we_o    = cpu_grant & cpu.we;
			ram_addr_o  = cpu.addr;
			ram_wdata_o = cpu.wdata;
		end
	end

	//--------------------------------------
	// Read response routing
	//--------------------------------------

	// Remember who owns the read in flight
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ld_rd_q  <= 1'b0;
			cpu_rd_q <= 1'b0;
		end else begin
			ld_rd_q  <= ld.valid & ~ld.we;
			cpu_rd_q <= cpu_grant & ~cpu.we;
		end
	end

	assign ld.rvalid  = ld_rd_q;
	assign cpu.rvalid = cpu_rd_q;

	// Shared read data, qualified by rvalid
	assign ld.rdata  = ram_rdata_i;
	assign cpu.rdata = ram_rdata_i;

endmodule

//--- design/cpu_bus_mapper.sv
//--------------------------------------
// Splits CPU cycles into RAM and I/O paths.
// Holds the e-disk register at port 0x10.
// Only one read response is ever in flight.
//--------------------------------------
`timescale 1ns/1ps

module cpu_bus_mapper import vector_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      cpu_valid_i,
	input  logic      cpu_io_i,
	input  logic      cpu_we_i,
	input  logic      cpu_stack_i,
	input  cpu_addr_t cpu_addr_i,
	input  byte_t     cpu_wdata_i,
	output logic      cpu_ready_o,
	output byte_t     cpu_rdata_o,
	output logic      cpu_rvalid_o,
	mem_bus_if.requester mem,
	output logic      io_valid_o,
	output logic      io_we_o,
	output byte_t     io_port_o,
	output byte_t     io_wdata_o,
	input  byte_t     io_rdata_i,
	input  logic      io_rvalid_i
);

	byte_t    ed_reg;
	ed_page_t ed_page;
	logic     edisk_sel;
	logic     edisk_acc;
	logic     edisk_rd_q;

	// Page select for one memory cycle
	function automatic ed_page_t map_page(input byte_t ed, input cpu_addr_t a,
		input logic stack);
		logic win;
		win = a[15] & ((a[14] ^ a[13]) | (ed[7] & a[14] & a[13])
			| (ed[6] & ~a[14] & ~a[13]));
		if (ed[4] && stack) begin
			map_page = ed_page_t'(ed[3:2]) + 3'd1;
		end else if (ed[5] && win) begin
			map_page = ed_page_t'(ed[1:0]) + 3'd1;
		end else begin
			map_page = '0;
		end
	endfunction

	//--------------------------------------
	// Memory path
	//--------------------------------------
	assign ed_page   = map_page(ed_reg, cpu_addr_i, cpu_stack_i);
	assign mem.valid = cpu_valid_i & ~cpu_io_i;
	assign mem.we    = cpu_we_i;
	assign mem.addr  = {ed_page, cpu_addr_i};
	assign mem.wdata = cpu_wdata_i;

	// I/O never stalls
	assign cpu_ready_o = cpu_io_i ? 1'b1 : mem.ready;

	//--------------------------------------
	// I/O path
	//--------------------------------------
	assign io_port_o  = cpu_addr_i[7:0];
	assign edisk_sel  = (io_port_o == PORT_EDISK);
	assign edisk_acc  = cpu_valid_i & cpu_io_i & edisk_sel;
	assign io_valid_o = cpu_valid_i & cpu_io_i & ~edisk_sel;
	assign io_we_o    = cpu_we_i;
	assign io_wdata_o = cpu_wdata_i;

	// New mapping is used from the next cycle on
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ed_reg     <= '0;
			edisk_rd_q <= 1'b0;
		end else begin
			if (edisk_acc && cpu_we_i) begin
				ed_reg <= cpu_wdata_i;
			end
			// Port 0x10 is write only
			edisk_rd_q <= edisk_acc & ~cpu_we_i;
		end
	end

	//--------------------------------------
	// Response merge
	//--------------------------------------
	assign cpu_rvalid_o = mem.rvalid | io_rvalid_i | edisk_rd_q;

	always_comb begin
		if (mem.rvalid) begin
			cpu_rdata_o = mem.rdata;
		end else if (io_rvalid_i) begin
			cpu_rdata_o = io_rdata_i;
		end else begin
			cpu_rdata_o = IO_IDLE_DATA;
		end
	end

endmodule

//--- design/io_ports.sv
//--------------------------------------
// Joystick ports and the Covox DAC latch.
// Reads are registered, one cycle latency.
// Covox writes are lost until the lock
// timer has run out after reset.
//--------------------------------------
`timescale 1ns/1ps

module io_ports import vector_pkg::*; (
	input  logic  clk_sys,
	input  logic  reset,
	input  logic  io_valid_i,
	input  logic  io_we_i,
	input  byte_t io_port_i,
	input  byte_t io_wdata_i,
	input  joy_t  joy_a_i,
	input  joy_t  joy_b_i,
	output byte_t io_rdata_o,
	output logic  io_rvalid_o,
	output byte_t audio_o
);

	logic  wr;
	logic  rd;
	logic  ctrl_sel;
	byte_t joy_mode;
	byte_t joy_a_port;
	byte_t joy_b_port;
	byte_t joy_sel_port;
	joy_t  joy_or;
	byte_t vox_port;
	byte_t rd_mux;
	byte_t rdata_q;
	logic  rvalid_q;
	byte_t vox_sample;
	logic [COVOX_TIMER_W-1:0] vox_timer;

	// Port layout of one stick, active low.
	// Bits 5:4 end up as 1 after the inversion
	function automatic byte_t joy_reorder(input joy_t j);
		joy_reorder = ~{j[5], j[4], 2'b00, j[2], j[3], j[1], j[0]};
	endfunction

	assign wr       = io_valid_i & io_we_i;
	assign rd       = io_valid_i & ~io_we_i;
	assign ctrl_sel = (io_port_i[7:1] == PORT_JOY_CTRL[7:1]);

	//--------------------------------------
	// Joystick mode register
	//--------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joy_mode <= '0;
		end else if (wr && ctrl_sel) begin
			if (io_port_i[0]) begin
				joy_mode <= io_wdata_i;
			end else if (!io_wdata_i[7]) begin
				// Single bit set or clear
				joy_mode[io_wdata_i[3:1]] <= io_wdata_i[0];
			end
		end
	end

	//--------------------------------------
	// Read data
	//--------------------------------------
	assign joy_a_port = joy_reorder(joy_a_i);
	assign joy_b_port = joy_reorder(joy_b_i);
	assign joy_or     = joy_a_i | joy_b_i;
	assign vox_port   = {joy_or[3], joy_or[0], joy_or[2], joy_or[1],
		joy_or[4], joy_or[5], 2'b00};

	always_comb begin
		case (joy_mode[6:5])
			2'b00:   joy_sel_port = joy_a_port & joy_b_port;
			2'b01:   joy_sel_port = joy_a_port;
			2'b10:   joy_sel_port = joy_b_port;
			default: joy_sel_port = 8'hFF;
		endcase
	end

	always_comb begin
		if (ctrl_sel) begin
			rd_mux = '0;
		end else begin
			case (io_port_i)
				PORT_JOY_SEL: rd_mux = joy_sel_port;
				PORT_VOX:     rd_mux = vox_port;
				PORT_JOY_A:   rd_mux = joy_a_port;
				PORT_JOY_B:   rd_mux = joy_b_port;
				default:      rd_mux = IO_IDLE_DATA;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rd) begin
			rdata_q <= rd_mux;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= rd;
		end
	end

	assign io_rdata_o  = rdata_q;
	assign io_rvalid_o = rvalid_q;

	//--------------------------------------
	// Covox
	//--------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vox_timer  <= COVOX_TIMER_W'(COVOX_LOCK_CYCLES);
			vox_sample <= '0;
		end else begin
			if (vox_timer != '0) begin
				vox_timer <= vox_timer - 1'b1;
			end
			if (wr && io_port_i == PORT_VOX && vox_timer == '0) begin
				vox_sample <= io_wdata_i;
			end
		end
	end

	assign audio_o = vox_sample;

endmodule

//--- design/vector_io_top.sv
//--------------------------------------
// Memory and I/O fabric top level.
// CPU cycles wait while the loader writes.
// Loader addresses must stay below RAM_DEPTH.
//--------------------------------------
`timescale 1ns/1ps

module vector_io_top import vector_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      cpu_valid_i,
	input  logic      cpu_io_i,
	input  logic      cpu_we_i,
	input  logic      cpu_stack_i,
	input  cpu_addr_t cpu_addr_i,
	input  byte_t     cpu_wdata_i,
	output logic      cpu_ready_o,
	output byte_t     cpu_rdata_o,
	output logic      cpu_rvalid_o,
	input  logic      ld_valid_i,
	input  ram_addr_t ld_addr_i,
	input  byte_t     ld_data_i,
	output logic      ld_ready_o,
	input  joy_t      joy_a_i,
	input  joy_t      joy_b_i,
	output byte_t     audio_o
);

	mem_bus_if cpu_mem_bus ();
	mem_bus_if ld_bus ();

	logic      io_valid;
	logic      io_we;
	byte_t     io_port;
	byte_t     io_wdata;
	byte_t     io_rdata;
	logic      io_rvalid;
	logic      ram_we;
	ram_addr_t ram_addr;
	byte_t     ram_wdata;
	byte_t     ram_rdata;

	// Loader is a write only requester
	assign ld_bus.valid = ld_valid_i;
	assign ld_bus.we    = 1'b1;
	assign ld_bus.addr  = ld_addr_i;
	assign ld_bus.wdata = ld_data_i;
	assign ld_ready_o   = ld_bus.ready;

	cpu_bus_mapper mapper_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu_valid_i (cpu_valid_i),
		.cpu_io_i    (cpu_io_i),
		.cpu_we_i    (cpu_we_i),
		.cpu_stack_i (cpu_stack_i),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_wdata_i (cpu_wdata_i),
		.cpu_ready_o (cpu_ready_o),
		.cpu_rdata_o (cpu_rdata_o),
		.cpu_rvalid_o(cpu_rvalid_o),
		.mem         (cpu_mem_bus.requester),
		.io_valid_o  (io_valid),
		.io_we_o     (io_we),
		.io_port_o   (io_port),
		.io_wdata_o  (io_wdata),
		.io_rdata_i  (io_rdata),
		.io_rvalid_i (io_rvalid)
	);

	io_ports io_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io_valid_i (io_valid),
		.io_we_i    (io_we),
		.io_port_i  (io_port),
		.io_wdata_i (io_wdata),
		.joy_a_i    (joy_a_i),
		.joy_b_i    (joy_b_i),
		.io_rdata_o (io_rdata),
		.io_rvalid_o(io_rvalid),
		.audio_o    (audio_o)
	);

	mem_arbiter arb_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ld         (ld_bus.arbiter),
		.cpu        (cpu_mem_bus.arbiter),
		.ram_we_o   (ram_we),
		.ram_addr_o (ram_addr),
		.ram_wdata_o(ram_wdata),
		.ram_rdata_i(ram_rdata)
	);

	shared_ram ram_i (
		.clk_sys(clk_sys),
		.we_i   (ram_we),
		.addr_i (ram_addr),
		.wdata_i(ram_wdata),
		.rdata_o(ram_rdata)
	);

endmodule

//--- dv/vector_io_checker.sv
//--------------------------------------
// Protocol and Covox checks on the top level
// ports. Bound into vector_io_top.
//--------------------------------------
`timescale 1ns/1ps

module vector_io_checker import vector_pkg::*; (
	input logic      clk_sys,
	input logic      reset,
	input logic      cpu_valid_i,
	input logic      cpu_io_i,
	input logic      cpu_we_i,
	input cpu_addr_t cpu_addr_i,
	input byte_t     cpu_wdata_i,
	input logic      cpu_ready_o,
	input logic      cpu_rvalid_o,
	input logic      ld_valid_i,
	input logic      ld_ready_o,
	input byte_t     audio_o
);

	// Failed assertion count, read by the testbench
	int   fail_cnt = 0;
	int   lock_age;
	logic rd_acc;
	logic vox_wr;

	assign rd_acc = cpu_valid_i & cpu_ready_o & ~cpu_we_i;
	assign vox_wr = cpu_valid_i & cpu_io_i & cpu_we_i & (cpu_addr_i[7:0] == PORT_VOX);

	// Cycles since reset, saturating at the lock length
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lock_age <= 0;
		end else if (lock_age < COVOX_LOCK_CYCLES) begin
			lock_age <= lock_age + 1;
		end
	end

	//--------------------------------------
	// Handshake
	//--------------------------------------
	a_ld_ready: assert property (@(posedge clk_sys) disable iff (reset)
		ld_valid_i |-> ld_ready_o)
		else begin $error("loader not ready while valid"); fail_cnt++; end

	a_cpu_stall: assert property (@(posedge clk_sys) disable iff (reset)
		ld_valid_i && cpu_valid_i && !cpu_io_i |-> !cpu_ready_o)
		else begin $error("memory cycle not stalled by loader"); fail_cnt++; end

	a_io_go: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_valid_i && cpu_io_i |-> cpu_ready_o)
		else begin $error("I/O cycle stalled"); fail_cnt++; end

	//--------------------------------------
	// Responses
	//--------------------------------------
	a_rd_resp: assert property (@(posedge clk_sys) disable iff (reset)
		rd_acc |=> cpu_rvalid_o)
		else begin $error("no response one cycle after read"); fail_cnt++; end

	a_no_resp: assert property (@(posedge clk_sys) disable iff (reset)
		!rd_acc |=> !cpu_rvalid_o)
		else begin $error("response without accepted read"); fail_cnt++; end

	a_reset_state: assert property (@(posedge clk_sys)
		reset |=> !cpu_rvalid_o && audio_o == 8'h00)
		else begin $error("outputs not cleared by reset"); fail_cnt++; end

	//--------------------------------------
	// Covox
	//--------------------------------------
	a_vox_locked: assert property (@(posedge clk_sys) disable iff (reset)
		vox_wr && lock_age < COVOX_LOCK_CYCLES |=> audio_o == $past(audio_o))
		else begin $error("Covox write taken during lock"); fail_cnt++; end

	a_vox_load: assert property (@(posedge clk_sys) disable iff (reset)
		vox_wr && lock_age == COVOX_LOCK_CYCLES |=> audio_o == $past(cpu_wdata_i))
		else begin $error("Covox write lost after lock"); fail_cnt++; end

endmodule

bind vector_io_top vector_io_checker chk_i (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.cpu_valid_i (cpu_valid_i),
	.cpu_io_i    (cpu_io_i),
	.cpu_we_i    (cpu_we_i),
	.cpu_addr_i  (cpu_addr_i),
	.cpu_wdata_i (cpu_wdata_i),
	.cpu_ready_o (cpu_ready_o),
	.cpu_rvalid_o(cpu_rvalid_o),
	.ld_valid_i  (ld_valid_i),
	.ld_ready_o  (ld_ready_o),
	.audio_o     (audio_o)
);

//--- dv/vector_io_tb.sv
//--------------------------------------
// Testbench for vector_io_top. The full RAM
// is filled through the loader first, which
// takes RAM_DEPTH cycles.
//--------------------------------------
`timescale 1ns/1ps

module vector_io_tb import vector_pkg::*; ();

	logic      clk_sys = 1'b0;
	logic      reset;
	logic      cpu_valid_i;
	logic      cpu_io_i;
	logic      cpu_we_i;
	logic      cpu_stack_i;
	cpu_addr_t cpu_addr_i;
	byte_t     cpu_wdata_i;
	logic      cpu_ready_o;
	byte_t     cpu_rdata_o;
	logic      cpu_rvalid_o;
	logic      ld_valid_i;
	ram_addr_t ld_addr_i;
	byte_t     ld_data_i;
	logic      ld_ready_o;
	joy_t      joy_a_i;
	joy_t      joy_b_i;
	byte_t     audio_o;

	int          errors = 0;
	int          checks = 0;
	int          test_num = 0;
	int          err_mark = 0;
	int          cycle_cnt = 0;
	logic [31:0] lfsr_state;

	vector_io_top dut_i (.*);

	always #20 clk_sys = ~clk_sys;

	//--------------------------------------
	// Helpers
	//--------------------------------------
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
		return b;
	endfunction

	function automatic byte_t rand_byte();
		byte_t v;
		for (int i = 0; i < 8; i++) begin
			v[i] = lfsr_bit();
		end
		return v;
	endfunction

	// Low address byte folded with the upper bits
	function automatic byte_t fill_byte(input ram_addr_t a);
		return a[7:0] ^ a[15:8] ^ {a[18:16], 5'b00000} ^ 8'h5A;
	endfunction

	function automatic ram_addr_t mapped_addr(input byte_t ed, input cpu_addr_t a,
		input logic stack);
		logic in_win;
		int   page;
		in_win = (a >= 16'hA000 && a <= 16'hDFFF) || (ed[7] && a >= 16'hE000)
			|| (ed[6] && a >= 16'h8000 && a <= 16'h9FFF);
		if (stack && ed[4]) begin
			page = ed[3:2] + 1;
		end else if (in_win && ed[5]) begin
			page = ed[1:0] + 1;
		end else begin
			page = 0;
		end
		return ram_addr_t'(page * 65536 + a);
	endfunction

	// Active low stick layout, bits 5:4 read high
	function automatic byte_t stick_port(input joy_t j);
		byte_t r;
		r = 8'h00;
		r[7] = j[5];
		r[6] = j[4];
		r[3] = j[2];
		r[2] = j[3];
		r[1] = j[1];
		r[0] = j[0];
		return ~r;
	endfunction

	function automatic byte_t vox_read(input joy_t a, input joy_t b);
		joy_t  o;
		byte_t r;
		o = a | b;
		r = 8'h00;
		r[7] = o[3];
		r[6] = o[0];
		r[5] = o[2];
		r[4] = o[1];
		r[3] = o[4];
		r[2] = o[5];
		return r;
	endfunction

	function automatic byte_t sel_read(input byte_t mode, input joy_t a, input joy_t b);
		case (mode[6:5])
			2'b00:   return stick_port(a) & stick_port(b);
			2'b01:   return stick_port(a);
			2'b10:   return stick_port(b);
			default: return 8'hFF;
		endcase
	endfunction

	// Cycle estimate per test, prefill dominates
	function automatic int run_budget();
		return 4 * ((RAM_DEPTH + 16) + 20 + 6 * (2 + 14 * 2) + 6 * (2 + 4 * 13)
			+ (COVOX_LOCK_CYCLES + 12) + 12 + 3);
	endfunction

	task automatic check_byte(input string what, input cpu_addr_t addr, input byte_t got,
		input byte_t exp);
		checks++;
		assert (got === exp) else begin
			$display("ERR %0t: %s at 0x%04h read 0x%02h, expected 0x%02h",
				$time, what, addr, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		int total;
		total = errors + dut_i.chk_i.fail_cnt;
		test_num++;
		$display("test %0d %s done, %0d errors", test_num, name, total - err_mark);
		err_mark = total;
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	// One CPU cycle, returns the read data one cycle after acceptance
	task automatic cpu_access(input logic io, input logic we, input logic stack,
		input cpu_addr_t addr, input byte_t wdata, output byte_t rdata);
		@(posedge clk_sys);
		cpu_valid_i <= 1'b1;
		cpu_io_i    <= io;
		cpu_we_i    <= we;
		cpu_stack_i <= stack;
		cpu_addr_i  <= addr;
		cpu_wdata_i <= wdata;
		do begin
			@(negedge clk_sys);
		end while (!cpu_ready_o);
		@(posedge clk_sys);
		cpu_valid_i <= 1'b0;
		@(negedge clk_sys);
		rdata = cpu_rdata_o;
	endtask

	task automatic cpu_write(input logic io, input cpu_addr_t addr, input byte_t data);
		byte_t unused;
		cpu_access(io, 1'b1, 1'b0, addr, data, unused);
	endtask

	task automatic expect_read(input string what, input logic io, input logic stack,
		input cpu_addr_t addr, input byte_t exp);
		byte_t got;
		cpu_access(io, 1'b0, stack, addr, 8'h00, got);
		check_byte(what, addr, got, exp);
	endtask

	//--------------------------------------
	// Run limit
	//--------------------------------------
	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= run_budget()) begin
			$display("Timeout after %0d cycles, a handshake never completed", cycle_cnt);
			$display("Verification failed");
			$finish;
		end
	end

	//--------------------------------------
	// Tests
	//--------------------------------------
	initial begin
		byte_t     ed_vals [6]    = '{8'h00, 8'h20, 8'h23, 8'hE1, 8'h1C, 8'h3E};
		cpu_addr_t addr_vals [7]  = '{16'h1234, 16'h8123, 16'hA456, 16'hC789,
			16'hDFFF, 16'hE010, 16'hFFFE};
		byte_t     mode_ports [6] = '{8'h05, 8'h05, 8'h05, 8'h04, 8'h04, 8'h04};
		byte_t     mode_data [6]  = '{8'h00, 8'h20, 8'h40, 8'h0B, 8'h0C, 8'h8D};
		byte_t     odd_ports [6]  = '{8'h00, 8'h08, 8'h10, 8'h1F, 8'h80, 8'hFF};
		byte_t     joy_mode;
		byte_t     wr_val;
		joy_t      ja;
		joy_t      jb;
		int        total;

		reset       <= 1'b1;
		cpu_valid_i <= 1'b0;
		cpu_io_i    <= 1'b0;
		cpu_we_i    <= 1'b0;
		cpu_stack_i <= 1'b0;
		cpu_addr_i  <= '0;
		cpu_wdata_i <= '0;
		ld_valid_i  <= 1'b0;
		ld_addr_i   <= '0;
		ld_data_i   <= '0;
		joy_a_i     <= '0;
		joy_b_i     <= '0;
		lfsr_state = 32'hd109_1860;
		apply_reset();

		// Loader fills the RAM while the CPU waits behind it
		fork
			begin
				for (int i = 0; i < RAM_DEPTH; i++) begin
					@(posedge clk_sys);
					ld_valid_i <= 1'b1;
					ld_addr_i  <= ram_addr_t'(i);
					ld_data_i  <= fill_byte(ram_addr_t'(i));
				end
				@(posedge clk_sys);
				ld_valid_i <= 1'b0;
			end
			begin
				repeat (8) @(posedge clk_sys);
				expect_read("edisk port", 1'b1, 1'b0, 16'h0010, IO_IDLE_DATA);
				expect_read("stalled read", 1'b0, 1'b0, 16'h1234, fill_byte(19'h01234));
			end
		join
		end_test("loader priority");

		wr_val = rand_byte();
		cpu_write(1'b0, 16'h0200, wr_val);
		expect_read("write back", 1'b0, 1'b0, 16'h0200, wr_val);
		// Back-to-back reads, each response lands while the next is accepted
		for (int i = 0; i <= 4; i++) begin
			@(posedge clk_sys);
			cpu_valid_i <= (i < 4);
			cpu_io_i    <= 1'b0;
			cpu_we_i    <= 1'b0;
			cpu_stack_i <= 1'b0;
			cpu_addr_i  <= 16'h3000 + 16'(i);
			@(negedge clk_sys);
			if (i > 0) begin
				check_byte("burst read", 16'h3000 + 16'(i - 1), cpu_rdata_o,
					fill_byte(ram_addr_t'(16'h3000 + 16'(i - 1))));
			end
		end
		end_test("response timing");

		foreach (ed_vals[e]) begin
			cpu_write(1'b1, 16'h0010, ed_vals[e]);
			foreach (addr_vals[k]) begin
				expect_read("mapped read", 1'b0, 1'b0, addr_vals[k],
					fill_byte(mapped_addr(ed_vals[e], addr_vals[k], 1'b0)));
				expect_read("stack read", 1'b0, 1'b1, addr_vals[k],
					fill_byte(mapped_addr(ed_vals[e], addr_vals[k], 1'b1)));
			end
		end
		cpu_write(1'b1, 16'h0010, 8'h00);
		end_test("edisk mapping");

		joy_mode = 8'h00;
		for (int m = 0; m < 6; m++) begin
			cpu_write(1'b1, {8'h00, mode_ports[m]}, mode_data[m]);
			if (mode_ports[m] == 8'h05) begin
				joy_mode = mode_data[m];
			end else if (!mode_data[m][7]) begin
				joy_mode[mode_data[m][3:1]] = mode_data[m][0];
			end
			repeat (4) begin
				ja = rand_byte();
				jb = rand_byte();
				@(posedge clk_sys);
				joy_a_i <= ja;
				joy_b_i <= jb;
				expect_read("joy ctrl", 1'b1, 1'b0, 16'h0004, 8'h00);
				expect_read("joy ctrl", 1'b1, 1'b0, 16'h0005, 8'h00);
				expect_read("joy select", 1'b1, 1'b0, 16'h0006, sel_read(joy_mode, ja, jb));
				expect_read("joy merged", 1'b1, 1'b0, 16'h0007, vox_read(ja, jb));
				expect_read("joy A", 1'b1, 1'b0, 16'h000E, stick_port(ja));
				expect_read("joy B", 1'b1, 1'b0, 16'h000F, stick_port(jb));
			end
		end
		end_test("joystick ports");

		// Fresh reset restarts the Covox lock
		apply_reset();
		cpu_write(1'b1, 16'h0007, 8'hA5);
		check_byte("locked covox", 16'h0007, audio_o, 8'h00);
		repeat (COVOX_LOCK_CYCLES) @(posedge clk_sys);
		wr_val = rand_byte() | 8'h01;
		cpu_write(1'b1, 16'h0007, wr_val);
		check_byte("covox sample", 16'h0007, audio_o, wr_val);
		end_test("covox lock");

		foreach (odd_ports[p]) begin
			expect_read("idle port", 1'b1, 1'b0, {8'hA5, odd_ports[p]}, IO_IDLE_DATA);
		end
		end_test("unmapped ports");

		total = errors + dut_i.chk_i.fail_cnt;
		$display("tests %0d, checks %0d, errors %0d", test_num, checks, total);
		if (total == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- vector_io.f
design/vector_pkg.sv
design/mem_bus_if.sv
design/shared_ram.sv
design/mem_arbiter.sv
design/cpu_bus_mapper.sv
design/io_ports.sv
design/vector_io_top.sv
dv/vector_io_checker.sv
dv/vector_io_tb.sv

//--- Makefile
# Verilator build and run for the memory and I/O fabric
TOOL    = verilator
FLAGS   = --binary --timing --assert -Wno-fatal
TOP     = vector_io_tb
FILES   = vector_io.f
OBJ_DIR = obj_dir
RUNOPTS = +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILES) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUNOPTS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
